// File: exu_ecl.f
src/exu_ecl_pkg.sv
src/ecl_dispatch.sv
src/ecl_bypass.sv
src/ecl_writeback.sv
src/exu_ecl.sv
tests/tb_clock.sv
tests/tb_exu_ecl.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
LINT_TOP  ?= exu_ecl
TOP       ?= tb_exu_ecl
FILELIST  ?= exu_ecl.f
OBJ_DIR   ?= obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --top-module $(LINT_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: tests/tb_exu_ecl.sv
`timescale 1ns/1ns
`default_nettype none

module tb_exu_ecl import exu_ecl_pkg::*; ();

   // cycle budget per test, used by the watchdog
   localparam int RESET_CYCLES = 12;
   localparam int ALU_CYCLES   = 8 * 2;
   localparam int WB_CYCLES    = 3 * 6;
   localparam int FWD_CYCLES   = 4 * 4;
   localparam int LSU_CYCLES   = 2 * 10;
   localparam int BR_CYCLES    = 3 * 6;
   localparam int MARGIN       = 50;
   localparam int WATCHDOG_NS  = (RESET_CYCLES + ALU_CYCLES + WB_CYCLES + FWD_CYCLES
                                  + LSU_CYCLES + BR_CYCLES + MARGIN) * 40;

   logic clk, rst_n;
   logic valid_d, rd2rj_d, rd_read_d, pc_rel_d, imm_use_d, double_read_d, rf_wen_d;
   logic [INST_W-1:0] inst_d;
   logic [GRLEN-1:0] pc_d, imm_d, br_offs_d, rs1_data_d, rs2_data_d;
   unit_t op_unit_d;
   logic [OP_CODE_W-1:0] op_code_d;
   logic [REG_ADDR_W-1:0] rf_target_d, lsu_rd_m;
   logic [GRLEN-1:0] alu_res_e, brpc_e, link_pc_e, lsu_rdata_m;
   logic br_taken_e, bru_wen_e, lsu_rdata_valid_m, lsu_wen_m;

   logic [REG_ADDR_W-1:0] rs1_d, rs2_d, lsu_rd_e, rd_w;
   logic [GRLEN-1:0] alu_a_e, alu_b_e, lsu_base_e, lsu_offset_e, lsu_wdata_e;
   logic [GRLEN-1:0] bru_a_e, bru_b_e, bru_pc_e, bru_offset_e, exu_brpc_e, rd_data_w;
   alu_op_t alu_op_e;
   lsu_op_t lsu_op_e;
   bru_op_t bru_op_e;
   logic lsu_valid_e, lsu_wen_e, bru_valid_e, exu_br_taken_e, stall_req, wen_w;

   logic [31:0] lfsr = 32'he97f;
   logic [31:0] draw;
   int errors = 0;
   int test_errors = 0;
   int tests_run = 0;
   int tests_failed = 0;

   tb_clock u_clock (.clk(clk), .rst_n(rst_n));

   exu_ecl u_exu_ecl (.*);

   // fibonacci lfsr, taps 32 22 2 1
   function automatic logic next_bit();
      logic fb;
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      return fb;
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
         v = {v[30:0], next_bit()};
      return v;
   endfunction

   task automatic check_value(input string name, input logic [GRLEN-1:0] got,
                              input logic [GRLEN-1:0] exp);
      assert (got === exp) else begin
         $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic start_test();
      test_errors = errors;
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (errors == test_errors) begin
         $display("%s: ok", name);
      end else begin
         tests_failed++;
         $display("%s: %0d checks wrong", name, errors - test_errors);
      end
   endtask

   task automatic drive_idle();
      valid_d           = 1'b0;
      inst_d            = '0;
      pc_d              = '0;
      op_unit_d         = UNIT_OTHER;
      op_code_d         = '0;
      rd2rj_d           = 1'b0;
      rd_read_d         = 1'b0;
      pc_rel_d          = 1'b0;
      imm_use_d         = 1'b0;
      double_read_d     = 1'b0;
      rf_wen_d          = 1'b0;
      rf_target_d       = '0;
      imm_d             = '0;
      br_offs_d         = '0;
      rs1_data_d        = '0;
      rs2_data_d        = '0;
      alu_res_e         = '0;
      br_taken_e        = 1'b0;
      brpc_e            = '0;
      link_pc_e         = '0;
      bru_wen_e         = 1'b0;
      lsu_rdata_m       = '0;
      lsu_rdata_valid_m = 1'b0;
      lsu_rd_m          = '0;
      lsu_wen_m         = 1'b0;
   endtask

   task automatic randomize_d();
      inst_d     = rand_bits(32);
      pc_d       = rand_bits(32);
      imm_d      = rand_bits(32);
      br_offs_d  = rand_bits(32);
      rs1_data_d = rand_bits(32);
      rs2_data_d = rand_bits(32);
   endtask

   task automatic check_reset_outputs();
      check_value("lsu_valid_e", 32'(lsu_valid_e), 32'd0);
      check_value("bru_valid_e", 32'(bru_valid_e), 32'd0);
      check_value("wen_w", 32'(wen_w), 32'd0);
      check_value("exu_br_taken_e", 32'(exu_br_taken_e), 32'd0);
      check_value("stall_req", 32'(stall_req), 32'd0);
   endtask

   task automatic test_reset();
      @(negedge clk);
      while (!rst_n) begin
         check_reset_outputs();
         @(negedge clk);
      end
      // at least one clock edge out of reset with idle inputs
      @(negedge clk);
      check_reset_outputs();
   endtask

   task automatic test_alu_operands();
      logic [3:0] op;
      logic [GRLEN-1:0] ea, eb;
      logic [REG_ADDR_W-1:0] f_rd, f_rj, f_rk, e1, e2;
      for (int i = 0; i < 8; i++) begin
         @(negedge clk);
         randomize_d();
         draw = rand_bits(4);
         op   = (i == 0) ? 4'(ALU_LUI) : draw[3:0];
         // fold the unused codes back into the valid range
         if (op > 4'd9)
            op = op - 4'd6;
         draw = rand_bits(15);
         f_rd = draw[4:0];
         f_rj = draw[9:5];
         f_rk = draw[14:10];
         inst_d[RD_LSB +: REG_ADDR_W] = f_rd;
         inst_d[RJ_LSB +: REG_ADDR_W] = f_rj;
         inst_d[RK_LSB +: REG_ADDR_W] = f_rk;
         valid_d   = 1'b1;
         op_unit_d = UNIT_ALU;
         op_code_d = op;
         rd2rj_d   = next_bit();
         rd_read_d = next_bit();
         pc_rel_d  = next_bit();
         imm_use_d = next_bit();
         e1 = rd2rj_d ? f_rd : f_rj;
         e2 = rd_read_d ? f_rd : f_rk;
         ea = (op == 4'(ALU_LUI)) ? '0 : (pc_rel_d ? pc_d : rs1_data_d);
         eb = imm_use_d ? imm_d : rs2_data_d;
         #1;
         check_value("rs1_d", 32'(rs1_d), 32'(e1));
         check_value("rs2_d", 32'(rs2_d), 32'(e2));
         @(negedge clk);
         check_value("alu_op_e", 32'(alu_op_e), 32'(op));
         check_value("alu_a_e", alu_a_e, ea);
         check_value("alu_b_e", alu_b_e, eb);
         drive_idle();
      end
   endtask

   // unit 0 alu, 1 branch link, 2 load data
   task automatic writeback_case(input int kind);
      logic [GRLEN-1:0] res, link;
      logic [REG_ADDR_W-1:0] tgt;
      res  = rand_bits(32);
      link = rand_bits(32);
      draw = rand_bits(5);
      tgt  = draw[4:0];
      @(negedge clk);
      drive_idle();
      if (kind == 2) begin
         lsu_rdata_valid_m = 1'b1;
         lsu_rdata_m       = res;
         lsu_rd_m          = tgt;
         lsu_wen_m         = 1'b1;
      end else begin
         randomize_d();
         valid_d     = 1'b1;
         op_unit_d   = (kind == 0) ? UNIT_ALU : UNIT_BRU;
         rf_wen_d    = (kind == 0);
         rf_target_d = tgt;
         @(negedge clk);
         drive_idle();
         alu_res_e = res;
         link_pc_e = link;
         bru_wen_e = (kind == 1);
         @(negedge clk);
         drive_idle();
      end
      @(negedge clk);
      drive_idle();
      check_value("rd_data_w", rd_data_w, (kind == 1) ? link : res);
      check_value("rd_w", 32'(rd_w), 32'(tgt));
      check_value("wen_w", 32'(wen_w), 32'd1);
      @(negedge clk);
   endtask

   task automatic fwd_case(input logic [REG_ADDR_W-1:0] tgt, input logic [REG_ADDR_W-1:0] src,
                           input logic pc_rel, input logic imm_use, input logic gap);
      logic [GRLEN-1:0] res, ea, eb;
      logic hit;
      @(negedge clk);
      drive_idle();
      randomize_d();
      valid_d     = 1'b1;
      op_unit_d   = UNIT_ALU;
      op_code_d   = 4'(ALU_ADD);
      rf_wen_d    = 1'b1;
      rf_target_d = tgt;
      @(negedge clk);
      drive_idle();
      res       = rand_bits(32);
      alu_res_e = res;
      if (gap) begin
         @(negedge clk);
         drive_idle();
      end
      randomize_d();
      inst_d[RJ_LSB +: REG_ADDR_W] = src;
      inst_d[RK_LSB +: REG_ADDR_W] = src;
      valid_d   = 1'b1;
      op_unit_d = UNIT_ALU;
      op_code_d = 4'(ALU_ADD);
      pc_rel_d  = pc_rel;
      imm_use_d = imm_use;
      hit = (src != '0) && (src == tgt);
      ea  = pc_rel ? pc_d : (hit ? res : rs1_data_d);
      eb  = imm_use ? imm_d : (hit ? res : rs2_data_d);
      @(negedge clk);
      check_value("alu_a_e", alu_a_e, ea);
      check_value("alu_b_e", alu_b_e, eb);
      drive_idle();
   endtask

   task automatic lsu_case(input logic dr);
      logic [3:0] lop;
      logic [GRLEN-1:0] b1, b2, imm;
      logic [REG_ADDR_W-1:0] tgt;
      @(negedge clk);
      drive_idle();
      randomize_d();
      lop  = next_bit() ? 4'(LSU_SW) : 4'(LSU_LW);
      draw = rand_bits(5);
      tgt  = draw[4:0];
      valid_d       = 1'b1;
      op_unit_d     = UNIT_LSU;
      op_code_d     = lop;
      rf_wen_d      = 1'b1;
      rf_target_d   = tgt;
      double_read_d = dr;
      b1  = rs1_data_d;
      b2  = rs2_data_d;
      imm = imm_d;
      #1;
      check_value("stall_req", 32'(stall_req), 32'd1);
      @(negedge clk);
      check_value("lsu_valid_e", 32'(lsu_valid_e), 32'd1);
      check_value("lsu_wen_e", 32'(lsu_wen_e), 32'd1);
      check_value("lsu_op_e", 32'(lsu_op_e), 32'(lop));
      check_value("lsu_base_e", lsu_base_e, b1);
      check_value("lsu_wdata_e", lsu_wdata_e, b2);
      check_value("lsu_rd_e", 32'(lsu_rd_e), 32'(tgt));
      check_value("lsu_offset_e", lsu_offset_e, dr ? b2 : imm);
      drive_idle();
      #1;
      check_value("stall_req", 32'(stall_req), 32'd1);
      draw = rand_bits(2);
      repeat (int'(draw[1:0]) + 1) begin
         @(negedge clk);
         check_value("stall_req", 32'(stall_req), 32'd1);
      end
      @(negedge clk);
      lsu_rdata_valid_m = 1'b1;
      #1;
      check_value("stall_req", 32'(stall_req), 32'd1);
      @(negedge clk);
      check_value("stall_req", 32'(stall_req), 32'd0);
      drive_idle();
   endtask

   task automatic branch_kill_case();
      logic [GRLEN-1:0] target, ba, bb, bpc, boffs;
      logic [3:0] bop;
      @(negedge clk);
      drive_idle();
      randomize_d();
      draw      = rand_bits(3);
      bop       = (draw[2:0] == 3'd7) ? 4'(BRU_BL) : {1'b0, draw[2:0]};
      valid_d   = 1'b1;
      op_unit_d = UNIT_BRU;
      op_code_d = bop;
      ba    = rs1_data_d;
      bb    = rs2_data_d;
      bpc   = pc_d;
      boffs = br_offs_d;
      @(negedge clk);
      check_value("bru_valid_e", 32'(bru_valid_e), 32'd1);
      check_value("bru_op_e", 32'(bru_op_e), 32'(bop));
      check_value("bru_a_e", bru_a_e, ba);
      check_value("bru_b_e", bru_b_e, bb);
      check_value("bru_pc_e", bru_pc_e, bpc);
      check_value("bru_offset_e", bru_offset_e, boffs);
      drive_idle();
      randomize_d();
      draw        = rand_bits(2);
      valid_d     = 1'b1;
      op_unit_d   = (draw[1:0] == 2'd3) ? UNIT_ALU : unit_t'(draw[1:0]);
      rf_wen_d    = 1'b1;
      draw        = rand_bits(5);
      rf_target_d = draw[4:0];
      target      = rand_bits(32);
      br_taken_e  = 1'b1;
      brpc_e      = target;
      #1;
      check_value("exu_br_taken_e", 32'(exu_br_taken_e), 32'd1);
      check_value("exu_brpc_e", exu_brpc_e, target);
      check_value("stall_req", 32'(stall_req), 32'd0);
      @(negedge clk);
      check_value("lsu_valid_e", 32'(lsu_valid_e), 32'd0);
      check_value("bru_valid_e", 32'(bru_valid_e), 32'd0);
      check_value("lsu_wen_e", 32'(lsu_wen_e), 32'd0);
      drive_idle();
      // taken flag alone, no branch in e
      br_taken_e = 1'b1;
      #1;
      check_value("exu_br_taken_e", 32'(exu_br_taken_e), 32'd0);
      br_taken_e = 1'b0;
      repeat (2) @(negedge clk);
      check_value("wen_w", 32'(wen_w), 32'd0);
   endtask

   initial begin
      drive_idle();
      start_test();
      test_reset();
      end_test("reset");
      start_test();
      test_alu_operands();
      end_test("alu operands");
      start_test();
      writeback_case(0);
      writeback_case(1);
      writeback_case(2);
      end_test("writeback merge");
      start_test();
      fwd_case(5'd7, 5'd7, 1'b0, 1'b0, 1'b0);
      fwd_case(5'd12, 5'd12, 1'b0, 1'b0, 1'b1);
      fwd_case(5'd0, 5'd0, 1'b0, 1'b0, 1'b0);
      fwd_case(5'd9, 5'd9, 1'b1, 1'b1, 1'b0);
      end_test("forwarding");
      start_test();
      lsu_case(1'b0);
      lsu_case(1'b1);
      end_test("load/store and stall");
      start_test();
      repeat (3) branch_kill_case();
      end_test("branch kill");
      $display("%0d tests, %0d failed, %0d checks wrong", tests_run, tests_failed, errors);
      if (errors == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

   initial begin
      #WATCHDOG_NS;
      $display("watchdog expired before the tests finished");
      $display("TEST FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
   output logic clk,
   output logic rst_n
);

   localparam int HALF_PERIOD = 20;
   localparam int RST_CYCLES  = 10;

   initial begin
      clk = 1'b0;
      forever #HALF_PERIOD clk = ~clk;
   end

   // release on a falling edge, away from the sampling edge
   initial begin
      rst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
   end

endmodule

`default_nettype wire

// File: src/exu_ecl.sv
`timescale 1ns/1ns
`default_nettype none

module exu_ecl import exu_ecl_pkg::*; (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  valid_d,
   input  logic [INST_W-1:0]     inst_d,
   input  logic [GRLEN-1:0]      pc_d,
   input  unit_t                 op_unit_d,
   input  logic [OP_CODE_W-1:0]  op_code_d,
   input  logic                  rd2rj_d,
   input  logic                  rd_read_d,
   input  logic                  pc_rel_d,
   input  logic                  imm_use_d,
   input  logic                  double_read_d,
   input  logic                  rf_wen_d,
   input  logic [REG_ADDR_W-1:0] rf_target_d,
   input  logic [GRLEN-1:0]      imm_d,
   input  logic [GRLEN-1:0]      br_offs_d,
   input  logic [GRLEN-1:0]      rs1_data_d,
   input  logic [GRLEN-1:0]      rs2_data_d,
   input  logic [GRLEN-1:0]      alu_res_e,
   input  logic                  br_taken_e,
   input  logic [GRLEN-1:0]      brpc_e,
   input  logic [GRLEN-1:0]      link_pc_e,
   input  logic                  bru_wen_e,
   input  logic [GRLEN-1:0]      lsu_rdata_m,
   input  logic                  lsu_rdata_valid_m,
   input  logic [REG_ADDR_W-1:0] lsu_rd_m,
   input  logic                  lsu_wen_m,

   output logic [REG_ADDR_W-1:0] rs1_d,
   output logic [REG_ADDR_W-1:0] rs2_d,
   output logic [GRLEN-1:0]      alu_a_e,
   output logic [GRLEN-1:0]      alu_b_e,
   output alu_op_t               alu_op_e,
   output logic                  lsu_valid_e,
   output lsu_op_t               lsu_op_e,
   output logic [GRLEN-1:0]      lsu_base_e,
   output logic [GRLEN-1:0]      lsu_offset_e,
   output logic [GRLEN-1:0]      lsu_wdata_e,
   output logic [REG_ADDR_W-1:0] lsu_rd_e,
   output logic                  lsu_wen_e,
   output logic                  bru_valid_e,
   output bru_op_t               bru_op_e,
   output logic [GRLEN-1:0]      bru_a_e,
   output logic [GRLEN-1:0]      bru_b_e,
   output logic [GRLEN-1:0]      bru_pc_e,
   output logic [GRLEN-1:0]      bru_offset_e,
   output logic [GRLEN-1:0]      exu_brpc_e,
   output logic                  exu_br_taken_e,
   output logic                  stall_req,
   output logic [GRLEN-1:0]      rd_data_w,
   output logic                  wen_w,
   output logic [REG_ADDR_W-1:0] rd_w
);

   // registered operands before forwarding
   logic [GRLEN-1:0]      alu_a_reg_e;
   logic [GRLEN-1:0]      alu_b_reg_e;
   logic [REG_ADDR_W-1:0] rs1_e;
   logic [REG_ADDR_W-1:0] rs2_e;
   logic                  fwd_a_ok_e;
   logic                  fwd_b_ok_e;
   logic                  double_read_e;
   logic [GRLEN-1:0]      imm_e;
   logic [REG_ADDR_W-1:0] rd_e;
   logic                  alu_wen_e;

   // results in flight
   logic [REG_ADDR_W-1:0] rd_m;
   logic                  wen_m;
   logic [GRLEN-1:0]      rd_data_m;

   assign exu_brpc_e = brpc_e;

   ecl_dispatch u_dispatch (
      .clk               (clk),
      .rst_n             (rst_n),
      .valid_d           (valid_d),
      .inst_d            (inst_d),
      .pc_d              (pc_d),
      .op_unit_d         (op_unit_d),
      .op_code_d         (op_code_d),
      .rd2rj_d           (rd2rj_d),
      .rd_read_d         (rd_read_d),
      .pc_rel_d          (pc_rel_d),
      .imm_use_d         (imm_use_d),
      .double_read_d     (double_read_d),
      .rf_wen_d          (rf_wen_d),
      .rf_target_d       (rf_target_d),
      .imm_d             (imm_d),
      .br_offs_d         (br_offs_d),
      .rs1_data_d        (rs1_data_d),
      .rs2_data_d        (rs2_data_d),
      .br_taken_e        (br_taken_e),
      .lsu_rdata_valid_m (lsu_rdata_valid_m),
      .rs1_d             (rs1_d),
      .rs2_d             (rs2_d),
      .alu_a_e           (alu_a_reg_e),
      .alu_b_e           (alu_b_reg_e),
      .alu_op_e          (alu_op_e),
      .rs1_e             (rs1_e),
      .rs2_e             (rs2_e),
      .fwd_a_ok_e        (fwd_a_ok_e),
      .fwd_b_ok_e        (fwd_b_ok_e),
      .double_read_e     (double_read_e),
      .imm_e             (imm_e),
      .rd_e              (rd_e),
      .alu_wen_e         (alu_wen_e),
      .lsu_valid_e       (lsu_valid_e),
      .lsu_op_e          (lsu_op_e),
      .lsu_rd_e          (lsu_rd_e),
      .lsu_wen_e         (lsu_wen_e),
      .bru_valid_e       (bru_valid_e),
      .bru_op_e          (bru_op_e),
      .bru_a_e           (bru_a_e),
      .bru_b_e           (bru_b_e),
      .bru_pc_e          (bru_pc_e),
      .bru_offset_e      (bru_offset_e),
      .exu_br_taken_e    (exu_br_taken_e),
      .stall_req         (stall_req)
   );

   ecl_bypass u_bypass (
      .alu_a_e       (alu_a_reg_e),
      .alu_b_e       (alu_b_reg_e),
      .rs1_e         (rs1_e),
      .rs2_e         (rs2_e),
      .fwd_a_ok_e    (fwd_a_ok_e),
      .fwd_b_ok_e    (fwd_b_ok_e),
      .double_read_e (double_read_e),
      .imm_e         (imm_e),
      .rd_m          (rd_m),
      .wen_m         (wen_m),
      .rd_data_m     (rd_data_m),
      .rd_w          (rd_w),
      .wen_w         (wen_w),
      .rd_data_w     (rd_data_w),
      .byp_a_e       (alu_a_e),
      .byp_b_e       (alu_b_e),
      .lsu_base_e    (lsu_base_e),
      .lsu_offset_e  (lsu_offset_e),
      .lsu_wdata_e   (lsu_wdata_e)
   );

   ecl_writeback u_writeback (
      .clk               (clk),
      .rst_n             (rst_n),
      .alu_res_e         (alu_res_e),
      .rd_e              (rd_e),
      .alu_wen_e         (alu_wen_e),
      .link_pc_e         (link_pc_e),
      .bru_wen_e         (bru_wen_e),
      .lsu_rdata_m       (lsu_rdata_m),
      .lsu_rdata_valid_m (lsu_rdata_valid_m),
      .lsu_rd_m          (lsu_rd_m),
      .lsu_wen_m         (lsu_wen_m),
      .rd_m              (rd_m),
      .wen_m             (wen_m),
      .rd_data_m         (rd_data_m),
      .rd_w              (rd_w),
      .wen_w             (wen_w),
      .rd_data_w         (rd_data_w)
   );

endmodule

`default_nettype wire

// File: src/ecl_writeback.sv
`timescale 1ns/1ns
`default_nettype none

module ecl_writeback import exu_ecl_pkg::*; (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic [GRLEN-1:0]      alu_res_e,
   input  logic [REG_ADDR_W-1:0] rd_e,
   input  logic                  alu_wen_e,
   input  logic [GRLEN-1:0]      link_pc_e,
   input  logic                  bru_wen_e,
   input  logic [GRLEN-1:0]      lsu_rdata_m,
   input  logic                  lsu_rdata_valid_m,
   input  logic [REG_ADDR_W-1:0] lsu_rd_m,
   input  logic                  lsu_wen_m,

   output logic [REG_ADDR_W-1:0] rd_m,
   output logic                  wen_m,
   output logic [GRLEN-1:0]      rd_data_m,
   output logic [REG_ADDR_W-1:0] rd_w,
   output logic                  wen_w,
   output logic [GRLEN-1:0]      rd_data_w
);

   logic [GRLEN-1:0]      alu_res_m;
   logic [REG_ADDR_W-1:0] rd_em;
   logic                  alu_wen_m;
   logic [GRLEN-1:0]      link_pc_m;
   logic                  bru_wen_m;

   // e to m payload
   always_ff @(posedge clk) begin
      alu_res_m <= alu_res_e;
      rd_em     <= rd_e;
      link_pc_m <= link_pc_e;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         alu_wen_m <= 1'b0;
         bru_wen_m <= 1'b0;
      end else begin
         alu_wen_m <= alu_wen_e;
         bru_wen_m <= bru_wen_e;
      end
   end

   // load data first, then the link address, alu result by default
   assign rd_m      = lsu_rdata_valid_m ? lsu_rd_m : rd_em;
   assign rd_data_m = lsu_rdata_valid_m ? lsu_rdata_m :
                      bru_wen_m         ? link_pc_m : alu_res_m;

   // any source may claim the write port
   assign wen_m = alu_wen_m | (lsu_wen_m & lsu_rdata_valid_m) | bru_wen_m;

   // m to w, feeds the register file write port
   always_ff @(posedge clk) begin
      rd_w      <= rd_m;
      rd_data_w <= rd_data_m;
   end

   always_ff @(posedge clk) begin
      if (!rst_n)
         wen_w <= 1'b0;
      else
         wen_w <= wen_m;
   end

endmodule

`default_nettype wire

// File: src/ecl_bypass.sv
`timescale 1ns/1ns
`default_nettype none

module ecl_bypass import exu_ecl_pkg::*; (
   input  logic [GRLEN-1:0]      alu_a_e,
   input  logic [GRLEN-1:0]      alu_b_e,
   input  logic [REG_ADDR_W-1:0] rs1_e,
   input  logic [REG_ADDR_W-1:0] rs2_e,
   input  logic                  fwd_a_ok_e,
   input  logic                  fwd_b_ok_e,
   input  logic                  double_read_e,
   input  logic [GRLEN-1:0]      imm_e,
   input  logic [REG_ADDR_W-1:0] rd_m,
   input  logic                  wen_m,
   input  logic [GRLEN-1:0]      rd_data_m,
   input  logic [REG_ADDR_W-1:0] rd_w,
   input  logic                  wen_w,
   input  logic [GRLEN-1:0]      rd_data_w,

   output logic [GRLEN-1:0]      byp_a_e,
   output logic [GRLEN-1:0]      byp_b_e,
   output logic [GRLEN-1:0]      lsu_base_e,
   output logic [GRLEN-1:0]      lsu_offset_e,
   output logic [GRLEN-1:0]      lsu_wdata_e
);

   // youngest producer wins, r0 is never forwarded
   function automatic logic [GRLEN-1:0] fwd_mux(
      input logic                  ok,
      input logic [REG_ADDR_W-1:0] rs,
      input logic [GRLEN-1:0]      reg_val
   );
      logic hit_m;
      logic hit_w;
      hit_m = ok && (rs != '0) && wen_m && (rs == rd_m);
      hit_w = ok && (rs != '0) && wen_w && (rs == rd_w);
      if (hit_m)
         return rd_data_m;
      else if (hit_w)
         return rd_data_w;
      else
         return reg_val;
   endfunction

   assign byp_a_e = fwd_mux(fwd_a_ok_e, rs1_e, alu_a_e);
   assign byp_b_e = fwd_mux(fwd_b_ok_e, rs2_e, alu_b_e);

   // load/store operands come off the forwarded values
   assign lsu_base_e   = byp_a_e;
   assign lsu_wdata_e  = byp_b_e;
   assign lsu_offset_e = double_read_e ? byp_b_e : imm_e;

endmodule

`default_nettype wire

// File: src/ecl_dispatch.sv
`timescale 1ns/1ns
`default_nettype none

module ecl_dispatch import exu_ecl_pkg::*; (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  valid_d,
   input  logic [INST_W-1:0]     inst_d,
   input  logic [GRLEN-1:0]      pc_d,
   input  unit_t                 op_unit_d,
   input  logic [OP_CODE_W-1:0]  op_code_d,
   input  logic                  rd2rj_d,
   input  logic                  rd_read_d,
   input  logic                  pc_rel_d,
   input  logic                  imm_use_d,
   input  logic                  double_read_d,
   input  logic                  rf_wen_d,
   input  logic [REG_ADDR_W-1:0] rf_target_d,
   input  logic [GRLEN-1:0]      imm_d,
   input  logic [GRLEN-1:0]      br_offs_d,
   input  logic [GRLEN-1:0]      rs1_data_d,
   input  logic [GRLEN-1:0]      rs2_data_d,
   input  logic                  br_taken_e,
   input  logic                  lsu_rdata_valid_m,

   output logic [REG_ADDR_W-1:0] rs1_d,
   output logic [REG_ADDR_W-1:0] rs2_d,
   output logic [GRLEN-1:0]      alu_a_e,
   output logic [GRLEN-1:0]      alu_b_e,
   output alu_op_t               alu_op_e,
   output logic [REG_ADDR_W-1:0] rs1_e,
   output logic [REG_ADDR_W-1:0] rs2_e,
   output logic                  fwd_a_ok_e,
   output logic                  fwd_b_ok_e,
   output logic                  double_read_e,
   output logic [GRLEN-1:0]      imm_e,
   output logic [REG_ADDR_W-1:0] rd_e,
   output logic                  alu_wen_e,
   output logic                  lsu_valid_e,
   output lsu_op_t               lsu_op_e,
   output logic [REG_ADDR_W-1:0] lsu_rd_e,
   output logic                  lsu_wen_e,
   output logic                  bru_valid_e,
   output bru_op_t               bru_op_e,
   output logic [GRLEN-1:0]      bru_a_e,
   output logic [GRLEN-1:0]      bru_b_e,
   output logic [GRLEN-1:0]      bru_pc_e,
   output logic [GRLEN-1:0]      bru_offset_e,
   output logic                  exu_br_taken_e,
   output logic                  stall_req
);

   logic                  live_d;
   logic                  is_alu_d;
   logic                  alu_dispatch_d;
   logic                  lsu_dispatch_d;
   logic                  bru_dispatch_d;
   logic                  a_zero_d;
   logic                  b_imm_d;
   logic [GRLEN-1:0]      alu_a_d;
   logic [GRLEN-1:0]      alu_b_d;
   logic [OP_CODE_W-1:0]  op_code_e;
   logic [REG_ADDR_W-1:0] rd_q;
   logic                  stall_q;

   // taken branch in e flushes whatever sits in d
   assign exu_br_taken_e = bru_valid_e & br_taken_e;
   assign live_d         = valid_d & ~exu_br_taken_e;

   // unit dispatch, UNIT_OTHER goes nowhere
   assign is_alu_d       = (op_unit_d == UNIT_ALU);
   assign alu_dispatch_d = live_d & is_alu_d;
   assign lsu_dispatch_d = live_d & (op_unit_d == UNIT_LSU);
   assign bru_dispatch_d = live_d & (op_unit_d == UNIT_BRU);

   // register file read addresses
   assign rs1_d = rd2rj_d   ? inst_d[RD_LSB +: REG_ADDR_W] : inst_d[RJ_LSB +: REG_ADDR_W];
   assign rs2_d = rd_read_d ? inst_d[RD_LSB +: REG_ADDR_W] : inst_d[RK_LSB +: REG_ADDR_W];

   // operand selects
   assign a_zero_d = is_alu_d & (alu_op_t'(op_code_d) == ALU_LUI);
   assign b_imm_d  = is_alu_d & imm_use_d;

   assign alu_a_d = a_zero_d ? '0 :
                    pc_rel_d ? pc_d : rs1_data_d;
   assign alu_b_d = b_imm_d ? imm_d : rs2_data_d;

   // d to e payload
   always_ff @(posedge clk) begin
      alu_a_e      <= alu_a_d;
      alu_b_e      <= alu_b_d;
      op_code_e    <= op_code_d;
      rs1_e        <= rs1_d;
      rs2_e        <= rs2_d;
      // pc, zero and immediate operands never take a forwarded value
      fwd_a_ok_e   <= ~(a_zero_d | pc_rel_d);
      fwd_b_ok_e   <= ~b_imm_d;
      imm_e        <= imm_d;
      rd_q         <= rf_target_d;
      bru_a_e      <= rs1_data_d;
      bru_b_e      <= rs2_data_d;
      bru_pc_e     <= pc_d;
      bru_offset_e <= br_offs_d;
   end

   // d to e control
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         alu_wen_e     <= 1'b0;
         lsu_valid_e   <= 1'b0;
         lsu_wen_e     <= 1'b0;
         bru_valid_e   <= 1'b0;
         double_read_e <= 1'b0;
         stall_q       <= 1'b0;
      end else begin
         alu_wen_e     <= rf_wen_d & alu_dispatch_d;
         lsu_valid_e   <= lsu_dispatch_d;
         lsu_wen_e     <= rf_wen_d & lsu_dispatch_d;
         bru_valid_e   <= bru_dispatch_d;
         double_read_e <= double_read_d & lsu_dispatch_d;
         // held until load data shows up at m
         stall_q       <= lsu_dispatch_d | (stall_q & ~lsu_rdata_valid_m);
      end
   end

   // one opcode register serves all three units
   assign alu_op_e = alu_op_t'(op_code_e);
   assign lsu_op_e = lsu_op_t'(op_code_e);
   assign bru_op_e = bru_op_t'(op_code_e);

   assign rd_e     = rd_q;
   assign lsu_rd_e = rd_q;

   // fetch stall, rises with the dispatch itself
   assign stall_req = lsu_dispatch_d | stall_q;

endmodule

`default_nettype wire

// File: src/exu_ecl_pkg.sv
`default_nettype none

package exu_ecl_pkg;

   // datapath and register file widths
   localparam int GRLEN      = 32;
   localparam int REG_ADDR_W = 5;
   localparam int INST_W     = 32;

   // register fields in the instruction word
   localparam int RD_LSB = 0;
   localparam int RJ_LSB = 5;
   localparam int RK_LSB = 10;

   localparam int OP_CODE_W = 4;

   // target unit of a decoded instruction
   typedef enum logic [1:0] {
      UNIT_ALU   = 2'd0,
      UNIT_LSU   = 2'd1,
      UNIT_BRU   = 2'd2,
      UNIT_OTHER = 2'd3
   } unit_t;

   typedef enum logic [OP_CODE_W-1:0] {
      ALU_ADD = 4'd0,
      ALU_SUB = 4'd1,
      ALU_AND = 4'd2,
      ALU_OR  = 4'd3,
      ALU_XOR = 4'd4,
      ALU_SLL = 4'd5,
      ALU_SRL = 4'd6,
      ALU_SRA = 4'd7,
      ALU_SLT = 4'd8,
      ALU_LUI = 4'd9
   } alu_op_t;

   typedef enum logic [OP_CODE_W-1:0] {
      LSU_LB = 4'd0,
      LSU_LH = 4'd1,
      LSU_LW = 4'd2,
      LSU_SB = 4'd4,
      LSU_SH = 4'd5,
      LSU_SW = 4'd6
   } lsu_op_t;

   typedef enum logic [OP_CODE_W-1:0] {
      BRU_BEQ  = 4'd0,
      BRU_BNE  = 4'd1,
      BRU_BLT  = 4'd2,
      BRU_BGE  = 4'd3,
      BRU_JIRL = 4'd4,
      BRU_B    = 4'd5,
      BRU_BL   = 4'd6
   } bru_op_t;

endpackage

`default_nettype wire
